// File: Makefile
VERILATOR ?= verilator
FLIST     ?= vlog.f
TB_TOP    ?= tb_bicubic_upsample
RTL_TOP   ?= bicubic_upsample
OBJ_DIR   ?= obj_dir
RTL_SRCS  ?= bicubic_pkg.sv bicubic_phase_ctrl.sv bicubic_vert_mac.sv \
             bicubic_horiz_mac.sv bicubic_out_stage.sv bicubic_upsample.sv
VFLAGS    ?= --timing --assert
PASS_MSG  ?= all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

$(OBJ_DIR)/V$(TB_TOP): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

sim: $(OBJ_DIR)/V$(TB_TOP)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: bicubic_horiz_mac.sv
// horizontal pass producing four output pixels from the four column results
`timescale 1ns/1ns

module bicubic_horiz_mac (
    input  logic                                        clk,
    input  logic                                        adv,
    input  logic signed [bicubic_pkg::INTER_WIDTH-1:0]   col1,
    input  logic signed [bicubic_pkg::INTER_WIDTH-1:0]   col2,
    input  logic signed [bicubic_pkg::INTER_WIDTH-1:0]   col3,
    input  logic signed [bicubic_pkg::INTER_WIDTH-1:0]   col4,
    output logic signed [bicubic_pkg::PRODUCT_WIDTH-1:0] prod1,
    output logic signed [bicubic_pkg::PRODUCT_WIDTH-1:0] prod2,
    output logic signed [bicubic_pkg::PRODUCT_WIDTH-1:0] prod3,
    output logic signed [bicubic_pkg::PRODUCT_WIDTH-1:0] prod4
);
    import bicubic_pkg::*;

    // output i sits at horizontal offset 1/8, 3/8, 5/8, 7/8
    localparam phase_t H_PHASE [4] = '{PH_U3, PH_U4, PH_U1, PH_U2};

    logic signed [INTER_WIDTH-1:0]   cols [4];
    logic signed [PRODUCT_WIDTH-1:0] prod_nxt [4];

    assign cols = '{col1, col2, col3, col4};

    always_comb begin
        logic signed [COEF_WIDTH-1:0] w;
        for (int i = 0; i < 4; i++) begin
            prod_nxt[i] = '0;
            for (int j = 0; j < 4; j++) begin
                w = coef_of(weight_set(H_PHASE[i], j + 1));
                prod_nxt[i] = prod_nxt[i] + w * cols[j];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (adv) begin
            prod1 <= prod_nxt[0];
            prod2 <= prod_nxt[1];
            prod3 <= prod_nxt[2];
            prod4 <= prod_nxt[3];
        end
    end

endmodule

// File: bicubic_out_stage.sv
// output stage with the valid and last pipeline, stall control and 8-bit saturation
`timescale 1ns/1ns

module bicubic_out_stage (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        accept,
    input  logic                                        last_tag,
    input  logic                                        out_ready,
    output logic                                        adv,
    input  logic signed [bicubic_pkg::PRODUCT_WIDTH-1:0] prod1,
    input  logic signed [bicubic_pkg::PRODUCT_WIDTH-1:0] prod2,
    input  logic signed [bicubic_pkg::PRODUCT_WIDTH-1:0] prod3,
    input  logic signed [bicubic_pkg::PRODUCT_WIDTH-1:0] prod4,
    output logic                                        out_valid,
    output logic                                        out_last,
    output logic [bicubic_pkg::CHANNEL_WIDTH-1:0]       out_pix1,
    output logic [bicubic_pkg::CHANNEL_WIDTH-1:0]       out_pix2,
    output logic [bicubic_pkg::CHANNEL_WIDTH-1:0]       out_pix3,
    output logic [bicubic_pkg::CHANNEL_WIDTH-1:0]       out_pix4
);
    import bicubic_pkg::*;

    logic [1:0] valid_pipe;
    logic [1:0] last_pipe;

    // floor divide by 2^22, then clamp to 0..255
    function automatic logic [CHANNEL_WIDTH-1:0] sat8(logic signed [PRODUCT_WIDTH-1:0] v);
        logic signed [PRODUCT_WIDTH-1:0] q;
        q = v >>> RESULT_SHIFT;
        if (q < 0)
            return '0;
        else if (q > (1 << CHANNEL_WIDTH) - 1)
            return '1;
        else
            return q[CHANNEL_WIDTH-1:0];
    endfunction

    // whole pipeline moves when the output slot is free or being taken
    assign adv = out_ready | ~out_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_pipe <= '0;
            last_pipe  <= '0;
        end else if (adv) begin
            valid_pipe <= {valid_pipe[0], accept};
            last_pipe  <= {last_pipe[0], accept & last_tag};
        end
    end

    assign out_valid = valid_pipe[1];
    assign out_last  = last_pipe[1];
    assign out_pix1  = sat8(prod1);
    assign out_pix2  = sat8(prod2);
    assign out_pix3  = sat8(prod3);
    assign out_pix4  = sat8(prod4);

    a_hold_on_stall: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> out_valid &&
        $stable({out_pix1, out_pix2, out_pix3, out_pix4, out_last}));

endmodule

// File: bicubic_phase_ctrl.sv
// frame position tracker that selects the vertical phase and tags the last window of a frame
`timescale 1ns/1ns

module bicubic_phase_ctrl #(
    parameter int BLOCK_WIDTH = 960,
    parameter int SRC_HEIGHT  = 540
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                accept,
    output bicubic_pkg::phase_t phase,
    output logic                last_tag
);
    import bicubic_pkg::*;

    localparam int COL_W = (BLOCK_WIDTH > 1) ? $clog2(BLOCK_WIDTH) : 1;
    localparam int ROW_W = (SRC_HEIGHT * 4 > 1) ? $clog2(SRC_HEIGHT * 4) : 1;

    logic [COL_W-1:0] col_cnt;
    logic [ROW_W-1:0] row_cnt;
    logic             last_col;
    logic             last_row;
    phase_t           phase_nxt;

    assign last_col = (col_cnt == COL_W'(BLOCK_WIDTH - 1));
    assign last_row = (row_cnt == ROW_W'(SRC_HEIGHT * 4 - 1));

    // out_stage qualifies this with accept
    assign last_tag = last_col & last_row;

    always_comb begin
        case (phase)
            PH_U1:   phase_nxt = PH_U2;
            PH_U2:   phase_nxt = PH_U3;
            PH_U3:   phase_nxt = PH_U4;
            default: phase_nxt = PH_U1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            col_cnt <= '0;
            row_cnt <= '0;
            phase   <= PH_U1;
        end else if (accept) begin
            if (last_col) begin
                col_cnt <= '0;
                if (last_row) begin
                    // end of frame restarts at the top
                    row_cnt <= '0;
                    phase   <= PH_U1;
                end else begin
                    row_cnt <= row_cnt + 1'b1;
                    phase   <= phase_nxt;
                end
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    a_phase_step: assert property (@(posedge clk) disable iff (rst)
        (phase != $past(phase)) |-> $past(accept && last_col));

endmodule

// File: bicubic_pkg.sv
// shared phase and weight code types, coefficient lookup and fixed-point widths for the upsampler
package bicubic_pkg;

    localparam int CHANNEL_WIDTH = 8;
    localparam int INTER_WIDTH   = 24;
    localparam int PRODUCT_WIDTH = 32;
    localparam int RESULT_SHIFT  = 22;
    localparam int COEF_WIDTH    = 12;

    // vertical phases at 5/8, 7/8, 1/8 and 3/8
    typedef enum logic [1:0] {
        PH_U1 = 2'd0,
        PH_U2 = 2'd1,
        PH_U3 = 2'd2,
        PH_U4 = 2'd3
    } phase_t;

    typedef enum logic [2:0] {
        W_N21   = 3'd0,
        W_N135  = 3'd1,
        W_N147  = 3'd2,
        W_N225  = 3'd3,
        W_P235  = 3'd4,
        W_P873  = 3'd5,
        W_P1535 = 3'd6,
        W_P1981 = 3'd7
    } wcode_t;

    // coefficient in units of 1/2048
    function automatic logic signed [COEF_WIDTH-1:0] coef_of(wcode_t code);
        case (code)
            W_N21:   return -12'sd21;
            W_N135:  return -12'sd135;
            W_N147:  return -12'sd147;
            W_N225:  return -12'sd225;
            W_P235:  return 12'sd235;
            W_P873:  return 12'sd873;
            W_P1535: return 12'sd1535;
            default: return 12'sd1981;
        endcase
    endfunction

    // tap runs 1..4 and each set sums to 2048
    function automatic wcode_t weight_set(phase_t ph, int tap);
        wcode_t ws [4];
        case (ph)
            PH_U1:   ws = '{W_N135, W_P873, W_P1535, W_N225};
            PH_U2:   ws = '{W_N21, W_P235, W_P1981, W_N147};
            PH_U3:   ws = '{W_N147, W_P1981, W_P235, W_N21};
            default: ws = '{W_N225, W_P1535, W_P873, W_N135};
        endcase
        return ws[tap - 1];
    endfunction

endpackage

// File: bicubic_upsample.sv
// 4x bicubic upsampler top taking a 4x4 window and producing four pixels per output row phase
`timescale 1ns/1ns

module bicubic_upsample #(
    parameter int BLOCK_WIDTH = 960,
    parameter int SRC_HEIGHT  = 540
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  in_valid,
    output logic                                  in_ready,
    input  logic [bicubic_pkg::CHANNEL_WIDTH-1:0] p1,
    input  logic [bicubic_pkg::CHANNEL_WIDTH-1:0] p2,
    input  logic [bicubic_pkg::CHANNEL_WIDTH-1:0] p3,
    input  logic [bicubic_pkg::CHANNEL_WIDTH-1:0] p4,
    input  logic [bicubic_pkg::CHANNEL_WIDTH-1:0] p5,
    input  logic [bicubic_pkg::CHANNEL_WIDTH-1:0] p6,
    input  logic [bicubic_pkg::CHANNEL_WIDTH-1:0] p7,
    input  logic [bicubic_pkg::CHANNEL_WIDTH-1:0] p8,
    input  logic [bicubic_pkg::CHANNEL_WIDTH-1:0] p9,
    input  logic [bicubic_pkg::CHANNEL_WIDTH-1:0] p10,
    input  logic [bicubic_pkg::CHANNEL_WIDTH-1:0] p11,
    input  logic [bicubic_pkg::CHANNEL_WIDTH-1:0] p12,
    input  logic [bicubic_pkg::CHANNEL_WIDTH-1:0] p13,
    input  logic [bicubic_pkg::CHANNEL_WIDTH-1:0] p14,
    input  logic [bicubic_pkg::CHANNEL_WIDTH-1:0] p15,
    input  logic [bicubic_pkg::CHANNEL_WIDTH-1:0] p16,
    output logic                                  out_valid,
    input  logic                                  out_ready,
    output logic [bicubic_pkg::CHANNEL_WIDTH-1:0] out_pix1,
    output logic [bicubic_pkg::CHANNEL_WIDTH-1:0] out_pix2,
    output logic [bicubic_pkg::CHANNEL_WIDTH-1:0] out_pix3,
    output logic [bicubic_pkg::CHANNEL_WIDTH-1:0] out_pix4,
    output logic                                  out_last
);
    import bicubic_pkg::*;

    logic                            adv;
    logic                            accept;
    logic                            last_tag;
    phase_t                          phase;
    logic signed [INTER_WIDTH-1:0]   col1, col2, col3, col4;
    logic signed [PRODUCT_WIDTH-1:0] prod1, prod2, prod3, prod4;

    assign in_ready = adv;
    assign accept   = in_valid & adv;

    bicubic_phase_ctrl #(
        .BLOCK_WIDTH (BLOCK_WIDTH),
        .SRC_HEIGHT  (SRC_HEIGHT)
    ) u_phase_ctrl (
        .clk      (clk),
        .rst      (rst),
        .accept   (accept),
        .phase    (phase),
        .last_tag (last_tag)
    );

    bicubic_vert_mac u_vert_mac (
        .clk   (clk),
        .adv   (adv),
        .phase (phase),
        .p1    (p1),
        .p2    (p2),
        .p3    (p3),
        .p4    (p4),
        .p5    (p5),
        .p6    (p6),
        .p7    (p7),
        .p8    (p8),
        .p9    (p9),
        .p10   (p10),
        .p11   (p11),
        .p12   (p12),
        .p13   (p13),
        .p14   (p14),
        .p15   (p15),
        .p16   (p16),
        .col1  (col1),
        .col2  (col2),
        .col3  (col3),
        .col4  (col4)
    );

    bicubic_horiz_mac u_horiz_mac (
        .clk   (clk),
        .adv   (adv),
        .col1  (col1),
        .col2  (col2),
        .col3  (col3),
        .col4  (col4),
        .prod1 (prod1),
        .prod2 (prod2),
        .prod3 (prod3),
        .prod4 (prod4)
    );

    bicubic_out_stage u_out_stage (
        .clk       (clk),
        .rst       (rst),
        .accept    (accept),
        .last_tag  (last_tag),
        .out_ready (out_ready),
        .adv       (adv),
        .prod1     (prod1),
        .prod2     (prod2),
        .prod3     (prod3),
        .prod4     (prod4),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_pix1  (out_pix1),
        .out_pix2  (out_pix2),
        .out_pix3  (out_pix3),
        .out_pix4  (out_pix4)
    );

endmodule

// File: bicubic_vert_mac.sv
// vertical pass that weights four pixel rows per column with the current phase vector
`timescale 1ns/1ns

module bicubic_vert_mac (
    input  logic                                    clk,
    input  logic                                    adv,
    input  bicubic_pkg::phase_t                     phase,
    input  logic [bicubic_pkg::CHANNEL_WIDTH-1:0]   p1,
    input  logic [bicubic_pkg::CHANNEL_WIDTH-1:0]   p2,
    input  logic [bicubic_pkg::CHANNEL_WIDTH-1:0]   p3,
    input  logic [bicubic_pkg::CHANNEL_WIDTH-1:0]   p4,
    input  logic [bicubic_pkg::CHANNEL_WIDTH-1:0]   p5,
    input  logic [bicubic_pkg::CHANNEL_WIDTH-1:0]   p6,
    input  logic [bicubic_pkg::CHANNEL_WIDTH-1:0]   p7,
    input  logic [bicubic_pkg::CHANNEL_WIDTH-1:0]   p8,
    input  logic [bicubic_pkg::CHANNEL_WIDTH-1:0]   p9,
    input  logic [bicubic_pkg::CHANNEL_WIDTH-1:0]   p10,
    input  logic [bicubic_pkg::CHANNEL_WIDTH-1:0]   p11,
    input  logic [bicubic_pkg::CHANNEL_WIDTH-1:0]   p12,
    input  logic [bicubic_pkg::CHANNEL_WIDTH-1:0]   p13,
    input  logic [bicubic_pkg::CHANNEL_WIDTH-1:0]   p14,
    input  logic [bicubic_pkg::CHANNEL_WIDTH-1:0]   p15,
    input  logic [bicubic_pkg::CHANNEL_WIDTH-1:0]   p16,
    output logic signed [bicubic_pkg::INTER_WIDTH-1:0] col1,
    output logic signed [bicubic_pkg::INTER_WIDTH-1:0] col2,
    output logic signed [bicubic_pkg::INTER_WIDTH-1:0] col3,
    output logic signed [bicubic_pkg::INTER_WIDTH-1:0] col4
);
    import bicubic_pkg::*;

    logic [CHANNEL_WIDTH-1:0]      pix [16];
    logic signed [INTER_WIDTH-1:0] col_nxt [4];

    // row-major window with p1..p4 as the top row
    assign pix = '{p1, p2, p3, p4, p5, p6, p7, p8,
                   p9, p10, p11, p12, p13, p14, p15, p16};

    always_comb begin
        logic signed [COEF_WIDTH-1:0] w;
        for (int j = 0; j < 4; j++) begin
            col_nxt[j] = '0;
        end
        for (int k = 0; k < 4; k++) begin
            w = coef_of(weight_set(phase, k + 1));
            for (int j = 0; j < 4; j++) begin
                // zero-extend so the pixel stays positive in signed math
                col_nxt[j] = col_nxt[j] + w * signed'({1'b0, pix[k*4 + j]});
            end
        end
    end

    always_ff @(posedge clk) begin
        if (adv) begin
            col1 <= col_nxt[0];
            col2 <= col_nxt[1];
            col3 <= col_nxt[2];
            col4 <= col_nxt[3];
        end
    end

endmodule

// File: tb_bicubic_upsample.sv
// testbench for the bicubic upsampler with a reference model and in-order output checking
`timescale 1ns/1ns

module tb_bicubic_upsample;
    import bicubic_pkg::*;

    localparam int BW             = 4;
    localparam int SH             = 2;
    localparam int FRAME          = BW * SH * 4;
    localparam int TOTAL_WINDOWS  = 5 * FRAME;
    localparam int TIMEOUT_CYCLES = TOTAL_WINDOWS * 4 + 100;

    typedef logic [CHANNEL_WIDTH-1:0] win_t [16];

    logic                     clk;
    logic                     rst;
    logic                     in_valid;
    logic                     in_ready;
    logic                     out_valid;
    logic                     out_ready = 1'b1;
    logic                     out_last;
    logic [CHANNEL_WIDTH-1:0] out_pix1, out_pix2, out_pix3, out_pix4;
    logic [CHANNEL_WIDTH-1:0] win [16];

    integer seed       = 32'h2eb6;
    integer ready_seed = 32'h2eb6 + 7;

    int          cyc = 0;
    int          accepts = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          failed_tests = 0;
    int          test_err_base;
    string       test_name;
    bit          rand_ready = 1'b0;
    bit          check_latency = 1'b0;
    bit          flat_check = 1'b0;
    bit          held = 1'b0;
    logic [31:0] held_pix;
    logic        held_last;
    logic [31:0] exp_pix_q [$];
    logic        exp_last_q [$];
    int          acc_cyc_q [$];

    tb_clk_gen #(.PERIOD(100)) u_clk_gen (.clk(clk));

    bicubic_upsample #(
        .BLOCK_WIDTH (BW),
        .SRC_HEIGHT  (SH)
    ) UUT (
        .p1  (win[0]),
        .p2  (win[1]),
        .p3  (win[2]),
        .p4  (win[3]),
        .p5  (win[4]),
        .p6  (win[5]),
        .p7  (win[6]),
        .p8  (win[7]),
        .p9  (win[8]),
        .p10 (win[9]),
        .p11 (win[10]),
        .p12 (win[11]),
        .p13 (win[12]),
        .p14 (win[13]),
        .p15 (win[14]),
        .p16 (win[15]),
        .*
    );

    // expected group with pix1 in the top byte
    function automatic logic [31:0] ref_window(win_t w, phase_t ph);
        phase_t      hph [4];
        longint      col [4];
        longint      acc;
        longint      c;
        longint      p;
        logic [31:0] res;
        hph = '{PH_U3, PH_U4, PH_U1, PH_U2};
        for (int j = 0; j < 4; j++) begin
            col[j] = 0;
            for (int k = 0; k < 4; k++) begin
                c = longint'(coef_of(weight_set(ph, k + 1)));
                p = longint'(w[k * 4 + j]);
                col[j] = col[j] + c * p;
            end
        end
        for (int i = 0; i < 4; i++) begin
            acc = 0;
            for (int j = 0; j < 4; j++) begin
                c = longint'(coef_of(weight_set(hph[i], j + 1)));
                acc = acc + c * col[j];
            end
            // floor of the 2^22 scale, then clamp to a byte
            acc = acc >>> RESULT_SHIFT;
            if (acc < 0)
                acc = 0;
            else if (acc > 255)
                acc = 255;
            res[(3 - i) * 8 +: 8] = acc[7:0];
        end
        return res;
    endfunction

    // row phase from the window count with four rows per phase cycle
    function automatic phase_t phase_of(int n);
        int r;
        r = ((n % FRAME) / BW) % 4;
        return phase_t'(r[1:0]);
    endfunction

    task automatic compare_pix(string what, int idx, logic [CHANNEL_WIDTH-1:0] got,
                               logic [CHANNEL_WIDTH-1:0] exp);
        checks++;
        if (got !== exp) begin
            $display("ERR %0t: %s pix%0d got %0d expected %0d", $time, what, idx, got, exp);
            errors++;
        end
    endtask

    task automatic compare_flag(string what, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic compare_cycles(string what, int got, int exp);
        checks++;
        if (got != exp) begin
            $display("ERR %0t: %s got %0d cycles expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic compare_group(string what, logic [31:0] got, logic [31:0] exp);
        for (int i = 0; i < 4; i++)
            compare_pix(what, i + 1, got[(3 - i) * 8 +: 8], exp[(3 - i) * 8 +: 8]);
    endtask

    // called on a rising edge and returns on the edge that accepts the window
    task automatic send_window(win_t w);
        for (int i = 0; i < 16; i++)
            win[i] <= w[i];
        in_valid <= 1'b1;
        @(negedge clk);
        while (!in_ready)
            @(negedge clk);
        @(posedge clk);
    endtask

    task automatic drain();
        in_valid <= 1'b0;
        for (int i = 0; i < 20 && exp_pix_q.size() != 0; i++)
            @(negedge clk);
        @(posedge clk);
    endtask

    task automatic start_test(string name);
        test_name     = name;
        test_err_base = errors;
        tests++;
    endtask

    task automatic finish_test();
        if (errors == test_err_base) begin
            $display("test %0d %s: ok", tests, test_name);
        end else begin
            $display("test %0d %s: %0d errors", tests, test_name, errors - test_err_base);
            failed_tests++;
        end
    endtask

    always @(posedge clk)
        cyc <= cyc + 1;

    always @(posedge clk) begin
        logic [31:0] r;
        r = $random(ready_seed);
        out_ready <= rand_ready ? r[0] : 1'b1;
    end

    // inputs change on the rising edge, so everything is sampled on the falling edge
    always @(negedge clk) begin
        logic [31:0] got;
        int          lat;
        got = {out_pix1, out_pix2, out_pix3, out_pix4};
        if (!rst) begin
            if (held) begin
                if (out_valid !== 1'b1) begin
                    $display("output group dropped during a stall at %0t", $time);
                    errors++;
                end
                compare_group("stall hold", got, held_pix);
                compare_flag("stall hold out_last", out_last, held_last);
            end
            if (out_valid && !out_ready)
                compare_flag("in_ready during stall", in_ready, 1'b0);
            held      = out_valid && !out_ready;
            held_pix  = got;
            held_last = out_last;
            if (out_valid && out_ready) begin
                if (exp_pix_q.size() == 0) begin
                    $display("output group at %0t has no matching input window", $time);
                    errors++;
                end else begin
                    compare_group("output", got, exp_pix_q.pop_front());
                    compare_flag("out_last", out_last, exp_last_q.pop_front());
                    lat = cyc - acc_cyc_q.pop_front();
                    if (check_latency)
                        compare_cycles("latency", lat, 2);
                end
            end
            if (in_valid && in_ready) begin
                if (flat_check)
                    exp_pix_q.push_back({4{win[0]}});
                else
                    exp_pix_q.push_back(ref_window(win, phase_of(accepts)));
                exp_last_q.push_back((accepts % FRAME) == FRAME - 1);
                acc_cyc_q.push_back(cyc);
                accepts++;
            end
        end
    end

    initial begin
        while (cyc < TIMEOUT_CYCLES)
            @(posedge clk);
        $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("tests failed");
        $finish;
    end

    initial begin
        win_t        w;
        logic [31:0] r;
        rst      = 1'b1;
        in_valid = 1'b0;
        for (int i = 0; i < 16; i++)
            win[i] = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        start_test("reset state");
        compare_flag("out_valid after reset", out_valid, 1'b0);
        compare_flag("out_last after reset", out_last, 1'b0);
        compare_flag("in_ready after reset", in_ready, 1'b1);
        finish_test();
        @(posedge clk);

        // weights of every set sum to 2048, so a flat window passes through
        start_test("flat windows");
        flat_check <= 1'b1;
        for (int n = 0; n < FRAME; n++) begin
            r = $random(seed);
            for (int i = 0; i < 16; i++)
                w[i] = (n == 0) ? 8'd0 : (n == 1) ? 8'd255 : r[7:0];
            send_window(w);
        end
        drain();
        flat_check <= 1'b0;
        finish_test();

        start_test("random frame");
        check_latency <= 1'b1;
        for (int n = 0; n < FRAME; n++) begin
            for (int i = 0; i < 16; i++) begin
                r = $random(seed);
                w[i] = r[7:0];
            end
            send_window(w);
        end
        drain();
        check_latency <= 1'b0;
        finish_test();

        start_test("saturation");
        for (int n = 0; n < FRAME; n++) begin
            for (int i = 0; i < 16; i++) begin
                case (n % 4)
                    0:       w[i] = ((i / 4 + i % 4) % 2 == 0) ? 8'd0 : 8'd255;
                    1:       w[i] = ((i / 4 + i % 4) % 2 == 0) ? 8'd255 : 8'd0;
                    2:       w[i] = (i == (n * 5) % 16) ? 8'd255 : 8'd0;
                    default: w[i] = (i / 4 inside {1, 2} && i % 4 inside {1, 2}) ? 8'd255 : 8'd0;
                endcase
            end
            send_window(w);
        end
        drain();
        finish_test();

        start_test("stalls over two frames");
        rand_ready <= 1'b1;
        for (int n = 0; n < 2 * FRAME; n++) begin
            r = $random(seed);
            if (r[1:0] == 2'd0) begin
                in_valid <= 1'b0;
                @(posedge clk);
            end
            for (int i = 0; i < 16; i++) begin
                r = $random(seed);
                w[i] = r[7:0];
            end
            send_window(w);
        end
        rand_ready <= 1'b0;
        drain();
        finish_test();

        if (exp_pix_q.size() != 0) begin
            $display("%0d output groups never arrived", exp_pix_q.size());
            errors++;
        end
        $display("tests run %0d, tests with errors %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// File: tb_clk_gen.sv
// testbench clock source with a fixed period
`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

// File: vlog.f
bicubic_pkg.sv
bicubic_phase_ctrl.sv
bicubic_vert_mac.sv
bicubic_horiz_mac.sv
bicubic_out_stage.sv
bicubic_upsample.sv
tb_clk_gen.sv
tb_bicubic_upsample.sv
